/* Makefile */
# Verilator flow for the AHB-Lite interconnect
# make lint, make sim, make clean

TB_TOP = tb_ahb_interconnect

.PHONY: lint sim clean

# static checks on the RTL top level
lint:
	verilator --lint-only -Wall --timescale 1ns/1ps -f ahb_interconnect.f \
		--top-module ahb_interconnect

# build and run the testbench, fail unless the pass line shows up
sim:
	verilator --binary --timing --timescale 1ns/1ps -f ahb_interconnect.f \
		--top-module $(TB_TOP)
	@out="$$(./obj_dir/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "All tests passed!"

clean:
	rm -rf obj_dir

/* ahb_interconnect.f */
+incdir+include
rtl/ahb_interconnect_pkg.sv
rtl/reset_synchronizer.sv
rtl/ahb_address_decoder.sv
rtl/ahb_response_mux.sv
rtl/ahb_interconnect.sv
verif/tb_ahb_interconnect.sv

/* include/ahb_interconnect_params.svh */
// bus widths and address map boundaries for the AHB-Lite interconnect
// included by the package and by every RTL file that sizes a bus port
`ifndef AHB_INTERCONNECT_PARAMS_SVH
`define AHB_INTERCONNECT_PARAMS_SVH

// master and slave bus widths
`define AHB_ADDR_WIDTH   32
`define AHB_DATA_WIDTH   32

// transfer type field
`define AHB_HTRANS_WIDTH 2

// response back to the master, upper bit unused
`define AHB_HRESP_WIDTH  2

// address map, checked in this order by the decoder

// sram holds everything below this address
`define SRAM_REGION_END   32'h8000_0000

// clint starts here and ends at the plic base
`define CLINT_REGION_BASE 32'hE000_0000

// plic base, also the exclusive end of clint
`define PLIC_REGION_BASE  32'hE001_0000

// exclusive end of plic, this address itself falls to apb
`define PLIC_REGION_END   32'hEFFF_FFFF

`endif

/* rtl/ahb_address_decoder.sv */
// address-phase decoder, maps haddr onto one of the four slave regions
// purely combinational, selects are valid in the same cycle as haddr and htrans
`timescale 1ns/1ps
`default_nettype none

`include "ahb_interconnect_params.svh"

module ahb_address_decoder (
    input  logic [`AHB_ADDR_WIDTH-1:0]     haddr,
    input  ahb_interconnect_pkg::htrans_t  htrans,
    output ahb_interconnect_pkg::map_region_t region,
    output logic                           sram_hsel,
    output logic                           apb_hsel,
    output logic                           plic_hsel,
    output logic                           clint_hsel
);

    // high for busy, nonseq and seq
    logic transfer_active;

    // per-region address hits
    logic in_sram;
    logic in_clint;
    logic in_plic;

    assign transfer_active = (htrans != ahb_interconnect_pkg::IDLE);

    // sram is everything below the boundary
    assign in_sram = (haddr < `SRAM_REGION_END);

    // clint window ends where plic starts
    assign in_clint = (haddr >= `CLINT_REGION_BASE) &&
                      (haddr <  `PLIC_REGION_BASE);

    // plic stops one short of the all-ones page
    // 0xefff_ffff itself drops through to apb
    assign in_plic = (haddr >= `PLIC_REGION_BASE) &&
                     (haddr <  `PLIC_REGION_END);

    // priority chain in map order
    // region stays valid even for idle transfers
    always_comb begin
        if (in_sram) begin
            region = ahb_interconnect_pkg::SRAM;
        end else if (in_clint) begin
            region = ahb_interconnect_pkg::CLINT;
        end else if (in_plic) begin
            region = ahb_interconnect_pkg::PLIC;
        end else begin
            // gap between sram and clint and the top of the map
            region = ahb_interconnect_pkg::APB;
        end
    end

    // one-hot selects, all low on idle
    assign sram_hsel  = transfer_active &&
                        (region == ahb_interconnect_pkg::SRAM);
    assign apb_hsel   = transfer_active &&
                        (region == ahb_interconnect_pkg::APB);
    assign plic_hsel  = transfer_active &&
                        (region == ahb_interconnect_pkg::PLIC);
    assign clint_hsel = transfer_active &&
                        (region == ahb_interconnect_pkg::CLINT);

endmodule

`default_nettype wire

/* rtl/ahb_interconnect.sv */
// AHB-Lite address interconnect between one master and four slave regions
// slaves take haddr, hwrite, hwdata and control from the master directly
`timescale 1ns/1ps
`default_nettype none

`include "ahb_interconnect_params.svh"

module ahb_interconnect (
    input  logic                              clk,
    input  logic                              async_reset,

    // master address phase
    input  ahb_interconnect_pkg::htrans_t     htrans,
    input  logic [`AHB_ADDR_WIDTH-1:0]        haddr,

    // response back to the master
    output logic                              hready,
    output logic [`AHB_HRESP_WIDTH-1:0]       hresp,
    output logic [`AHB_DATA_WIDTH-1:0]        hrdata,

    // slave selects, one per region
    output logic                              sram_hsel,
    output logic                              apb_hsel,
    output logic                              plic_hsel,
    output logic                              clint_hsel,

    // muxed ready fed back to every slave
    output logic                              hready_slave,

    // sram slave response
    input  logic                              sram_hreadyout,
    input  logic                              sram_hresp,
    input  logic [`AHB_DATA_WIDTH-1:0]        sram_hrdata,

    // apb bridge slave response
    input  logic                              apb_hreadyout,
    input  logic                              apb_hresp,
    input  logic [`AHB_DATA_WIDTH-1:0]        apb_hrdata,

    // plic slave response
    input  logic                              plic_hreadyout,
    input  logic                              plic_hresp,
    input  logic [`AHB_DATA_WIDTH-1:0]        plic_hrdata,

    // clint slave response
    input  logic                              clint_hreadyout,
    input  logic                              clint_hresp,
    input  logic [`AHB_DATA_WIDTH-1:0]        clint_hrdata
);

    // reset released in step with clk
    logic rst_n;

    // address-phase region from the decoder
    ahb_interconnect_pkg::map_region_t decode_region;

    // external reset enters here only
    reset_synchronizer u_reset_synchronizer (
        .clk         (clk),
        .async_reset (async_reset),
        .sync_reset  (rst_n)
    );

    // address phase, combinational
    ahb_address_decoder u_ahb_address_decoder (
        .haddr      (haddr),
        .htrans     (htrans),
        .region     (decode_region),
        .sram_hsel  (sram_hsel),
        .apb_hsel   (apb_hsel),
        .plic_hsel  (plic_hsel),
        .clint_hsel (clint_hsel)
    );

    // data phase, registered region then combinational mux
    ahb_response_mux u_ahb_response_mux (
        .clk             (clk),
        .rst_n           (rst_n),
        .region          (decode_region),
        .sram_hreadyout  (sram_hreadyout),
        .apb_hreadyout   (apb_hreadyout),
        .plic_hreadyout  (plic_hreadyout),
        .clint_hreadyout (clint_hreadyout),
        .sram_hresp      (sram_hresp),
        .apb_hresp       (apb_hresp),
        .plic_hresp      (plic_hresp),
        .clint_hresp     (clint_hresp),
        .sram_hrdata     (sram_hrdata),
        .apb_hrdata      (apb_hrdata),
        .plic_hrdata     (plic_hrdata),
        .clint_hrdata    (clint_hrdata),
        .hready          (hready),
        .hresp           (hresp),
        .hrdata          (hrdata)
    );

    // slaves see the same ready the master sees
    assign hready_slave = hready;

endmodule

`default_nettype wire

/* rtl/ahb_interconnect_pkg.sv */
// shared types for the AHB-Lite interconnect
// referenced by scoped name from the RTL and the testbench
`default_nettype none

`include "ahb_interconnect_params.svh"

package ahb_interconnect_pkg;

    // slave region that owns a transfer
    // encoding follows the original soc map order
    typedef enum logic [1:0] {
        SRAM  = 2'd0,
        APB   = 2'd1,
        PLIC  = 2'd2,
        CLINT = 2'd3
    } map_region_t;

    // ahb transfer type as driven by the master
    typedef enum logic [`AHB_HTRANS_WIDTH-1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

endpackage

`default_nettype wire

/* rtl/ahb_response_mux.sv */
// data-phase response mux, returns ready, response and read data to the master
// region register loads the decoded region on every edge where hready is high
`timescale 1ns/1ps
`default_nettype none

`include "ahb_interconnect_params.svh"

module ahb_response_mux (
    input  logic                              clk,
    input  logic                              rst_n,
    input  ahb_interconnect_pkg::map_region_t region,

    // slave ready lines
    input  logic                              sram_hreadyout,
    input  logic                              apb_hreadyout,
    input  logic                              plic_hreadyout,
    input  logic                              clint_hreadyout,

    // slave error bits
    input  logic                              sram_hresp,
    input  logic                              apb_hresp,
    input  logic                              plic_hresp,
    input  logic                              clint_hresp,

    // slave read data
    input  logic [`AHB_DATA_WIDTH-1:0]        sram_hrdata,
    input  logic [`AHB_DATA_WIDTH-1:0]        apb_hrdata,
    input  logic [`AHB_DATA_WIDTH-1:0]        plic_hrdata,
    input  logic [`AHB_DATA_WIDTH-1:0]        clint_hrdata,

    // muxed response to the master
    output logic                              hready,
    output logic [`AHB_HRESP_WIDTH-1:0]       hresp,
    output logic [`AHB_DATA_WIDTH-1:0]        hrdata
);

    // region that owns the current data phase
    ahb_interconnect_pkg::map_region_t data_region;

    // error bit of the owning slave
    logic resp_bit;

    // address phase accepted when hready is high
    // a stalled slave keeps ownership while haddr moves on
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // no transfer yet, sram answers by default
            data_region <= ahb_interconnect_pkg::SRAM;
        end else if (hready) begin
            data_region <= region;
        end
    end

    // plain pass-through of the owning slave
    always_comb begin
        case (data_region)
            ahb_interconnect_pkg::SRAM: begin
                hready   = sram_hreadyout;
                resp_bit = sram_hresp;
                hrdata   = sram_hrdata;
            end
            ahb_interconnect_pkg::APB: begin
                hready   = apb_hreadyout;
                resp_bit = apb_hresp;
                hrdata   = apb_hrdata;
            end
            ahb_interconnect_pkg::PLIC: begin
                hready   = plic_hreadyout;
                resp_bit = plic_hresp;
                hrdata   = plic_hrdata;
            end
            ahb_interconnect_pkg::CLINT: begin
                hready   = clint_hreadyout;
                resp_bit = clint_hresp;
                hrdata   = clint_hrdata;
            end
            default: begin
                // unknown encoding, drive a quiet response
                hready   = 1'b0;
                resp_bit = 1'b0;
                hrdata   = '0;
            end
        endcase
    end

    // ahb-lite slaves only report okay or error
    assign hresp = {{(`AHB_HRESP_WIDTH-1){1'b0}}, resp_bit};

endmodule

`default_nettype wire

/* rtl/reset_synchronizer.sv */
// turns the external asynchronous reset into one that releases on the clock
// asserts at once, releases on the second rising edge after async_reset goes high
`timescale 1ns/1ps
`default_nettype none

module reset_synchronizer (
    input  logic clk,
    input  logic async_reset,
    output logic sync_reset
);

    // first stage, may go metastable on release
    logic meta_flop;

    // both stages clear together, then a one shifts through
    always_ff @(posedge clk or negedge async_reset) begin
        if (!async_reset) begin
            meta_flop  <= 1'b0;
            sync_reset <= 1'b0;
        end else begin
            meta_flop  <= 1'b1;
            sync_reset <= meta_flop;
        end
    end

endmodule

`default_nettype wire

/* verif/tb_ahb_interconnect.sv */
// random-stimulus testbench for the AHB-Lite interconnect
// plays the master and four slaves and checks selects and responses against a model
`timescale 1ns/1ps
`default_nettype none

`include "ahb_interconnect_params.svh"

module tb_ahb_interconnect;

    localparam int RESET_CYCLES     = 5;
    localparam int NUM_BOUNDARY     = 10;
    localparam int NUM_RANDOM       = 3000;
    // each boundary address goes out once active and once idle
    localparam int NUM_TRANSACTIONS = 2 * NUM_BOUNDARY + NUM_RANDOM;
    localparam int TIMEOUT_CYCLES   = NUM_TRANSACTIONS * 4 + RESET_CYCLES;

    // edges of the address map and the ends of the space
    // first entry lies outside sram so an early reset release shows up
    localparam logic [31:0] BOUNDARY_ADDR [NUM_BOUNDARY] = '{
        32'h8000_0000, 32'h7FFF_FFFF, 32'hDFFF_FFFF, 32'hE000_0000, 32'hE000_FFFF,
        32'hE001_0000, 32'hEFFF_FFFE, 32'hEFFF_FFFF, 32'h0000_0000, 32'hFFFF_FFFF
    };

    logic                              clk;
    logic                              async_reset;
    ahb_interconnect_pkg::htrans_t     htrans;
    logic [`AHB_ADDR_WIDTH-1:0]        haddr;
    logic                              hready;
    logic [`AHB_HRESP_WIDTH-1:0]       hresp;
    logic [`AHB_DATA_WIDTH-1:0]        hrdata;
    logic                              sram_hsel;
    logic                              apb_hsel;
    logic                              plic_hsel;
    logic                              clint_hsel;
    logic                              hready_slave;
    logic                              sram_hreadyout;
    logic                              sram_hresp;
    logic [`AHB_DATA_WIDTH-1:0]        sram_hrdata;
    logic                              apb_hreadyout;
    logic                              apb_hresp;
    logic [`AHB_DATA_WIDTH-1:0]        apb_hrdata;
    logic                              plic_hreadyout;
    logic                              plic_hresp;
    logic [`AHB_DATA_WIDTH-1:0]        plic_hrdata;
    logic                              clint_hreadyout;
    logic                              clint_hresp;
    logic [`AHB_DATA_WIDTH-1:0]        clint_hrdata;

    // model of the data phase and of the reset release
    ahb_interconnect_pkg::map_region_t model_region;
    logic                              model_ready;
    logic                              model_meta;
    logic                              model_rst_n;

    int cycle_count = 0;
    // stalls where the master already points at another region
    int stall_moves = 0;

    ahb_interconnect uut (
        .clk             (clk),
        .async_reset     (async_reset),
        .htrans          (htrans),
        .haddr           (haddr),
        .hready          (hready),
        .hresp           (hresp),
        .hrdata          (hrdata),
        .sram_hsel       (sram_hsel),
        .apb_hsel        (apb_hsel),
        .plic_hsel       (plic_hsel),
        .clint_hsel      (clint_hsel),
        .hready_slave    (hready_slave),
        .sram_hreadyout  (sram_hreadyout),
        .sram_hresp      (sram_hresp),
        .sram_hrdata     (sram_hrdata),
        .apb_hreadyout   (apb_hreadyout),
        .apb_hresp       (apb_hresp),
        .apb_hrdata      (apb_hrdata),
        .plic_hreadyout  (plic_hreadyout),
        .plic_hresp      (plic_hresp),
        .plic_hrdata     (plic_hrdata),
        .clint_hreadyout (clint_hreadyout),
        .clint_hresp     (clint_hresp),
        .clint_hrdata    (clint_hrdata)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Test failures found");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // address map written as inclusive ranges
    function automatic ahb_interconnect_pkg::map_region_t model_decode(input logic [31:0] addr);
        if (addr <= 32'h7FFF_FFFF) begin
            return ahb_interconnect_pkg::SRAM;
        end else if (addr >= 32'hE000_0000 && addr <= 32'hE000_FFFF) begin
            return ahb_interconnect_pkg::CLINT;
        end else if (addr >= 32'hE001_0000 && addr <= 32'hEFFF_FFFE) begin
            return ahb_interconnect_pkg::PLIC;
        end else begin
            return ahb_interconnect_pkg::APB;
        end
    endfunction

    // mostly on or next to a boundary and sometimes anywhere
    function automatic logic [31:0] pick_address();
        logic [31:0] rnd;
        logic [31:0] offset;
        int          idx;
        rnd    = $urandom;
        offset = $urandom;
        idx    = int'(rnd[7:4]) % NUM_BOUNDARY;
        case (rnd[1:0])
            2'd0, 2'd1: return BOUNDARY_ADDR[idx] + {{28{offset[3]}}, offset[3:0]};
            2'd2:       return BOUNDARY_ADDR[idx];
            default:    return offset;
        endcase
    endfunction

    // slaves answer with fresh random values every cycle
    task automatic drive_slaves();
        logic [31:0] rnd;
        rnd = $urandom;
        // ready three times in four so transfers keep moving
        sram_hreadyout  = (rnd[1:0] != 2'b00);
        apb_hreadyout   = (rnd[3:2] != 2'b00);
        plic_hreadyout  = (rnd[5:4] != 2'b00);
        clint_hreadyout = (rnd[7:6] != 2'b00);
        sram_hresp      = rnd[8];
        apb_hresp       = rnd[9];
        plic_hresp      = rnd[10];
        clint_hresp     = rnd[11];
        sram_hrdata     = $urandom;
        apb_hrdata      = $urandom;
        plic_hrdata     = $urandom;
        clint_hrdata    = $urandom;
    endtask

    task automatic check_outputs();
        logic                              exp_resp;
        logic [31:0]                       exp_rdata;
        logic                              active;
        ahb_interconnect_pkg::map_region_t addr_region;
        // response of the slave that owns the data phase
        case (model_region)
            ahb_interconnect_pkg::SRAM: begin
                model_ready = sram_hreadyout;
                exp_resp    = sram_hresp;
                exp_rdata   = sram_hrdata;
            end
            ahb_interconnect_pkg::APB: begin
                model_ready = apb_hreadyout;
                exp_resp    = apb_hresp;
                exp_rdata   = apb_hrdata;
            end
            ahb_interconnect_pkg::PLIC: begin
                model_ready = plic_hreadyout;
                exp_resp    = plic_hresp;
                exp_rdata   = plic_hrdata;
            end
            default: begin
                model_ready = clint_hreadyout;
                exp_resp    = clint_hresp;
                exp_rdata   = clint_hrdata;
            end
        endcase
        addr_region = model_decode(haddr);
        active      = (htrans != ahb_interconnect_pkg::IDLE);
        check_value(32'(sram_hsel),
                    32'(active && addr_region == ahb_interconnect_pkg::SRAM), "sram_hsel");
        check_value(32'(apb_hsel),
                    32'(active && addr_region == ahb_interconnect_pkg::APB), "apb_hsel");
        check_value(32'(plic_hsel),
                    32'(active && addr_region == ahb_interconnect_pkg::PLIC), "plic_hsel");
        check_value(32'(clint_hsel),
                    32'(active && addr_region == ahb_interconnect_pkg::CLINT), "clint_hsel");
        check_value(32'(sram_hsel) + 32'(apb_hsel) + 32'(plic_hsel) + 32'(clint_hsel),
                    32'(active), "number of selects high");
        check_value(32'(hready), 32'(model_ready), "hready");
        check_value(32'(hready_slave), 32'(model_ready), "hready_slave");
        check_value(32'(hresp[0]), 32'(exp_resp), "hresp low bit");
        check_value(32'(hresp[1]), 32'd0, "hresp upper bit");
        check_value(hrdata, exp_rdata, "hrdata");
    endtask

    // rising edge and the matching step of the model
    task automatic advance_clock();
        @(posedge clk);
        if (model_rst_n && !model_ready && htrans != ahb_interconnect_pkg::IDLE &&
            model_decode(haddr) != model_region) begin
            stall_moves = stall_moves + 1;
        end
        // accepted address phase moves into the data phase
        if (model_rst_n && model_ready) begin
            model_region = model_decode(haddr);
        end
        model_rst_n = model_meta;
        model_meta  = 1'b1;
        if (!async_reset) begin
            model_rst_n = 1'b0;
            model_meta  = 1'b0;
        end
    endtask

    // one bus cycle with inputs changed on the falling edge
    task automatic run_cycle(input logic [31:0] addr, input ahb_interconnect_pkg::htrans_t trans,
                             input logic reset_level);
        @(negedge clk);
        async_reset = reset_level;
        haddr       = addr;
        htrans      = trans;
        drive_slaves();
        // outputs settled well before the next rising edge
        #5;
        check_outputs();
        advance_clock();
    endtask

    initial begin
        logic [31:0] rnd;
        void'($urandom(47590));
        async_reset  = 1'b0;
        htrans       = ahb_interconnect_pkg::IDLE;
        haddr        = '0;
        drive_slaves();
        model_region = ahb_interconnect_pkg::SRAM;
        model_ready  = 1'b0;
        model_meta   = 1'b0;
        model_rst_n  = 1'b0;

        // sram owns the response while reset is low
        // one rising edge already passed before the first falling edge
        repeat (RESET_CYCLES - 1) begin
            run_cycle(pick_address(), ahb_interconnect_pkg::NONSEQ, 1'b0);
        end

        // every boundary address once active and once idle
        for (int i = 0; i < NUM_BOUNDARY; i++) begin
            run_cycle(BOUNDARY_ADDR[i], ahb_interconnect_pkg::NONSEQ, 1'b1);
            run_cycle(BOUNDARY_ADDR[i], ahb_interconnect_pkg::IDLE, 1'b1);
        end

        // random traffic with random back-pressure
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd = $urandom;
            run_cycle(pick_address(), ahb_interconnect_pkg::htrans_t'(rnd[1:0]), 1'b1);
        end

        // back-pressure with a moving address must have come up
        check_value(32'(stall_moves > 0), 32'd1, "stalls with haddr in another region");

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire
